/* src/mm_pkg.sv */
// matrix multiplier shared definitions
package mm_pkg;

    // ====================
    // array and datapath sizes
    // ====================
    localparam int array_dim = 4;
    localparam int op_width  = 8;
    localparam int acc_width = 32;

    // bus geometry
    localparam int bus_width  = 32;
    localparam int addr_width = 8;

    // row memories, 16 rows each
    localparam int row_depth      = 16;
    localparam int row_addr_width = 4;

    // ====================
    // region codes, address bits 7:6
    // ====================
    localparam logic [1:0] region_ctrl   = 2'b00;
    localparam logic [1:0] region_input  = 2'b01;
    localparam logic [1:0] region_weight = 2'b10;
    localparam logic [1:0] region_output = 2'b11;

    // command codes, control write bits 3:0
    // any other code is a no-op
    localparam logic [3:0] op_reset        = 4'b1111;
    localparam logic [3:0] op_load_weights = 4'b0001;
    localparam logic [3:0] op_multiply     = 4'b0011;

    // ====================
    // row payloads
    // ====================
    // element i sits in bits 8i+7:8i
    typedef logic [array_dim-1:0][op_width-1:0] op_row_t;
    // one 32-bit sum per output column
    typedef logic [array_dim-1:0][acc_width-1:0] acc_row_t;

endpackage

/* src/mm_row_ram.sv */
// synchronous row memory
`timescale 1ns/1ns

module mm_row_ram import mm_pkg::*; #(
    parameter type row_t = op_row_t
) (
    input  logic                      clk,
    input  logic                      wr_en,
    input  logic [row_addr_width-1:0] wr_row,
    input  row_t                      wr_data,
    input  logic [row_addr_width-1:0] rd_row,
    output row_t                      rd_data
);

    // one row per entry
    row_t mem [row_depth];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_row] <= wr_data;
        end
    end

    // read port, one cycle, old data on a same-row write
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_row];
    end

endmodule

/* src/mm_bus_regs.sv */
// bus decode and control registers
`timescale 1ns/1ns

module mm_bus_regs import mm_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [addr_width-1:0]     bus_addr,
    input  logic                      bus_write,
    input  logic                      bus_read,
    input  logic [bus_width-1:0]      bus_wdata,
    input  logic                      load_done,
    input  logic                      mult_done,
    input  acc_row_t                  out_rd_data,
    output logic [bus_width-1:0]      bus_rdata,
    output logic                      in_wr_en,
    output logic                      w_wr_en,
    output logic [row_addr_width-1:0] wr_row,
    output op_row_t                   wr_data,
    output logic [row_addr_width-1:0] out_rd_row,
    output logic                      load_start,
    output logic                      mult_start,
    output logic [row_addr_width-1:0] src_base,
    output logic [row_addr_width-1:0] dst_base,
    output logic [row_addr_width-1:0] row_count,
    output logic                      engine_clear
);

    logic [1:0]                region;
    logic [3:0]                opcode;
    logic                      cmd_ok;
    logic                      engine_busy;
    logic                      weights_loaded;
    logic                      multiply_done;
    // captured at the read strobe
    logic [1:0]                rd_region_q;
    logic [1:0]                rd_col_q;
    logic [1:0]                rd_stat_q;
    logic [row_addr_width-1:0] rd_row_q;

    assign region = bus_addr[addr_width-1 -: 2];
    assign opcode = bus_wdata[3:0];

    // ====================
    // memory writes
    // ====================
    // whole-row writes at word index bits 3:0
    assign in_wr_en = bus_write && (region == region_input);
    assign w_wr_en  = bus_write && (region == region_weight);
    assign wr_row   = bus_addr[row_addr_width-1:0];
    assign wr_data  = op_row_t'(bus_wdata);

    // reset always goes through while other commands wait for idle
    assign cmd_ok = bus_write && (region == region_ctrl)
                    && (!engine_busy || (opcode == op_reset));

    // ====================
    // command and status
    // ====================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_start     <= 1'b0;
            mult_start     <= 1'b0;
            engine_clear   <= 1'b0;
            engine_busy    <= 1'b0;
            weights_loaded <= 1'b0;
            multiply_done  <= 1'b0;
            src_base       <= '0;
            dst_base       <= '0;
            row_count      <= '0;
        end else begin
            // single-cycle pulses
            load_start   <= 1'b0;
            mult_start   <= 1'b0;
            engine_clear <= 1'b0;
            if (cmd_ok) begin
                weights_loaded <= 1'b0;
                multiply_done  <= 1'b0;
                case (opcode)
                    op_reset: begin
                        engine_clear <= 1'b1;
                        engine_busy  <= 1'b0;
                    end
                    op_load_weights: begin
                        load_start  <= 1'b1;
                        engine_busy <= 1'b1;
                        src_base    <= bus_wdata[7:4];
                    end
                    op_multiply: begin
                        mult_start  <= 1'b1;
                        engine_busy <= 1'b1;
                        src_base    <= bus_wdata[7:4];
                        dst_base    <= bus_wdata[11:8];
                        row_count   <= bus_wdata[15:12];
                    end
                    default: begin
                        // no-op only clears the status bits
                    end
                endcase
            end else if (engine_clear) begin
                // late done pulses from a cleared run are dropped
                weights_loaded <= 1'b0;
                multiply_done  <= 1'b0;
            end else begin
                if (load_done) weights_loaded <= 1'b1;
                if (mult_done) multiply_done <= 1'b1;
                if (load_done || mult_done) engine_busy <= 1'b0;
            end
        end
    end

    // ====================
    // read path
    // ====================
    // output ram register acts as the data stage and holds the row between reads
    assign out_rd_row = bus_read ? bus_addr[5:2] : rd_row_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_region_q <= region_ctrl;
            rd_col_q    <= '0;
            rd_stat_q   <= '0;
            rd_row_q    <= '0;
        end else if (bus_read) begin
            rd_region_q <= region;
            rd_col_q    <= bus_addr[1:0];
            rd_stat_q   <= {multiply_done, weights_loaded};
            rd_row_q    <= bus_addr[5:2];
        end
    end

    // input and weight regions read back as zero
    always_comb begin
        case (rd_region_q)
            region_ctrl:   bus_rdata = {{(bus_width-2){1'b0}}, rd_stat_q};
            region_output: bus_rdata = out_rd_data[rd_col_q];
            default:       bus_rdata = '0;
        endcase
    end

    // bus master never drives both strobes
    a_strobes: assert property (@(posedge clk) disable iff (!arst_n)
        !(bus_read && bus_write))
        else $error("bus read and write strobes high together");

endmodule

/* src/mm_array_feeder.sv */
// systolic array feeder
`timescale 1ns/1ns

module mm_array_feeder import mm_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      load_start,
    input  logic                      mult_start,
    input  logic [row_addr_width-1:0] src_base,
    input  logic [row_addr_width-1:0] row_count,
    input  logic                      engine_clear,
    input  op_row_t                   w_rd_data,
    input  op_row_t                   in_rd_data,
    output logic [row_addr_width-1:0] w_rd_row,
    output logic [row_addr_width-1:0] in_rd_row,
    output logic [array_dim-1:0]      weight_shift,
    output op_row_t                   weight_in,
    output op_row_t                   a_in,
    output logic                      stream_valid,
    output logic                      load_done,
    output logic                      busy
);

    logic                      start_load;
    logic                      start_mult;
    logic                      run_load;
    logic                      run_mult;
    logic [row_addr_width-1:0] rd_idx;
    logic [row_addr_width-1:0] rd_left;
    // ram data stage
    logic                      ld_valid;
    logic [row_addr_width-1:0] ld_step;
    logic                      m_valid;
    logic [array_dim-1:0]      sv_pipe;
    op_row_t                   a_now;
    op_row_t                   skew [array_dim-1];

    assign busy = run_load || run_mult || ld_valid || m_valid || (|sv_pipe);
    // first read goes out in the start cycle itself
    assign start_load = load_start && !busy;
    assign start_mult = mult_start && !busy;

    // weights go bottom row first, they shift down the columns
    assign w_rd_row  = src_base + row_addr_width'(array_dim - 1) - rd_idx;
    assign in_rd_row = src_base + rd_idx;

    // ====================
    // read sequencer
    // ====================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run_load  <= 1'b0;
            run_mult  <= 1'b0;
            rd_idx    <= '0;
            rd_left   <= '0;
            ld_valid  <= 1'b0;
            ld_step   <= '0;
            m_valid   <= 1'b0;
            sv_pipe   <= '0;
            load_done <= 1'b0;
        end else if (engine_clear) begin
            run_load  <= 1'b0;
            run_mult  <= 1'b0;
            rd_idx    <= '0;
            rd_left   <= '0;
            ld_valid  <= 1'b0;
            ld_step   <= '0;
            m_valid   <= 1'b0;
            sv_pipe   <= '0;
            load_done <= 1'b0;
        end else begin
            ld_valid  <= start_load || run_load;
            ld_step   <= rd_idx;
            m_valid   <= start_mult || run_mult;
            // valid follows row 0 down to the bottom of column 0
            sv_pipe   <= {sv_pipe[array_dim-2:0], m_valid};
            load_done <= ld_valid && (ld_step == row_addr_width'(array_dim - 1));
            if (start_load) begin
                run_load <= 1'b1;
                rd_idx   <= row_addr_width'(1);
                rd_left  <= row_addr_width'(array_dim - 1);
            end else if (start_mult) begin
                // single-row run finishes in the start cycle
                run_mult <= (row_count != '0);
                rd_idx   <= (row_count != '0) ? row_addr_width'(1) : '0;
                rd_left  <= row_count;
            end else if (run_load || run_mult) begin
                if (rd_left == row_addr_width'(1)) begin
                    run_load <= 1'b0;
                    run_mult <= 1'b0;
                    rd_idx   <= '0;
                end else begin
                    rd_idx  <= rd_idx + 1'b1;
                    rd_left <= rd_left - 1'b1;
                end
            end
        end
    end

    // ====================
    // weight load
    // ====================
    // rows below the data front hold still
    always_comb begin
        for (int r = 0; r < array_dim; r++) begin
            weight_shift[r] = ld_valid && (ld_step >= row_addr_width'(r));
        end
    end
    assign weight_in = w_rd_data;

    // ====================
    // input skew
    // ====================
    // idle slots carry zeros
    assign a_now = m_valid ? in_rd_data : '0;

    always_ff @(posedge clk) begin
        skew[0] <= a_now;
        for (int k = 1; k < array_dim - 1; k++) begin
            skew[k] <= skew[k-1];
        end
    end

    // row r late by r cycles
    always_comb begin
        a_in[0] = a_now[0];
        for (int r = 1; r < array_dim; r++) begin
            a_in[r] = skew[r-1][r];
        end
    end

    assign stream_valid = sv_pipe[array_dim-1];

    // bus side holds commands back while the engine runs
    a_no_start_busy: assert property (@(posedge clk) disable iff (!arst_n)
        (load_start || mult_start) |-> !busy)
        else $error("command start while array feeder busy");

endmodule

/* src/mm_mac_cell.sv */
// weight-stationary mac cell
`timescale 1ns/1ns

module mm_mac_cell import mm_pkg::*; (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        weight_shift,
    input  logic signed [op_width-1:0]  weight_in,
    input  logic signed [op_width-1:0]  a_in,
    input  logic signed [acc_width-1:0] psum_in,
    output logic signed [op_width-1:0]  weight_out,
    output logic signed [op_width-1:0]  a_out,
    output logic signed [acc_width-1:0] psum_out
);

    logic signed [op_width-1:0] weight_q;

    // weight chain down the column
    assign weight_out = weight_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            weight_q <= '0;
            a_out    <= '0;
            psum_out <= '0;
        end else begin
            if (weight_shift) begin
                weight_q <= weight_in;
            end
            // activation moves right one column per cycle
            a_out    <= a_in;
            // signed product, sign-extended into the sum
            psum_out <= psum_in + weight_q * a_in;
        end
    end

    // weight settled once its load ends
    a_weight_known: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(weight_shift) |-> !$isunknown(weight_q))
        else $error("stationary weight unknown after load");

endmodule

/* src/mm_result_drain.sv */
// result deskew and writeback
`timescale 1ns/1ns

module mm_result_drain import mm_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      stream_valid,
    input  acc_row_t                  col_sums,
    input  logic [row_addr_width-1:0] dst_base,
    input  logic                      engine_clear,
    output logic                      out_wr_en,
    output logic [row_addr_width-1:0] out_wr_row,
    output acc_row_t                  out_wr_data,
    output logic                      mult_done
);

    // valid aligned with column 0, three more cycles to column 3
    logic [array_dim-2:0] v_pipe;
    logic                 wr_en_q;
    acc_row_t             dly [array_dim-1];

    // ====================
    // deskew
    // ====================
    always_ff @(posedge clk) begin
        dly[0] <= col_sums;
        for (int k = 1; k < array_dim - 1; k++) begin
            dly[k] <= dly[k-1];
        end
    end

    // column c waits array_dim-1-c cycles
    always_comb begin
        out_wr_data[array_dim-1] = col_sums[array_dim-1];
        for (int c = 0; c < array_dim - 1; c++) begin
            out_wr_data[c] = dly[array_dim-2-c][c];
        end
    end

    assign out_wr_en = v_pipe[array_dim-2];

    // ====================
    // row pointer, done
    // ====================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            v_pipe     <= '0;
            wr_en_q    <= 1'b0;
            out_wr_row <= '0;
        end else if (engine_clear) begin
            v_pipe     <= '0;
            wr_en_q    <= 1'b0;
            out_wr_row <= dst_base;
        end else begin
            v_pipe  <= {v_pipe[array_dim-3:0], stream_valid};
            wr_en_q <= out_wr_en;
            // tracks the base while idle
            if (out_wr_en) begin
                out_wr_row <= out_wr_row + 1'b1;
            end else begin
                out_wr_row <= dst_base;
            end
        end
    end

    // rows arrive back to back, so the run ends at the first gap
    assign mult_done = wr_en_q && !out_wr_en;

endmodule

/* src/mm_top.sv */
// bus-mapped matrix multiplier top
`timescale 1ns/1ns

module mm_top import mm_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [addr_width-1:0] bus_addr,
    input  logic                  bus_write,
    input  logic                  bus_read,
    input  logic [bus_width-1:0]  bus_wdata,
    output logic [bus_width-1:0]  bus_rdata
);

    logic                      in_wr_en;
    logic                      w_wr_en;
    logic [row_addr_width-1:0] wr_row;
    op_row_t                   wr_data;
    logic [row_addr_width-1:0] out_rd_row;
    acc_row_t                  out_rd_data;
    logic                      load_start;
    logic                      mult_start;
    logic [row_addr_width-1:0] src_base;
    logic [row_addr_width-1:0] dst_base;
    logic [row_addr_width-1:0] row_count;
    logic                      engine_clear;
    logic                      load_done;
    logic                      mult_done;
    logic [row_addr_width-1:0] w_rd_row;
    logic [row_addr_width-1:0] in_rd_row;
    op_row_t                   w_rd_data;
    op_row_t                   in_rd_data;
    logic [array_dim-1:0]      weight_shift;
    op_row_t                   feed_w;
    op_row_t                   feed_a;
    logic                      stream_valid;
    acc_row_t                  col_sums;
    logic                      out_wr_en;
    logic [row_addr_width-1:0] out_wr_row;
    acc_row_t                  out_wr_data;
    // ====================
    // cell mesh
    // ====================
    // a right along rows, weights and sums down columns
    logic [op_width-1:0]  a_bus [array_dim][array_dim+1];
    logic [op_width-1:0]  w_bus [array_dim+1][array_dim];
    logic [acc_width-1:0] p_bus [array_dim+1][array_dim];

    mm_bus_regs u_regs (
        .clk, .arst_n, .bus_addr, .bus_write, .bus_read, .bus_wdata,
        .load_done, .mult_done, .out_rd_data, .bus_rdata, .in_wr_en, .w_wr_en,
        .wr_row, .wr_data, .out_rd_row, .load_start, .mult_start,
        .src_base, .dst_base, .row_count, .engine_clear
    );

    mm_row_ram #(.row_t(op_row_t)) u_in_ram (
        .clk, .wr_en(in_wr_en), .wr_row, .wr_data, .rd_row(in_rd_row), .rd_data(in_rd_data)
    );

    mm_row_ram #(.row_t(op_row_t)) u_w_ram (
        .clk, .wr_en(w_wr_en), .wr_row, .wr_data, .rd_row(w_rd_row), .rd_data(w_rd_data)
    );

    // bus reads share the read port with nothing else
    mm_row_ram #(.row_t(acc_row_t)) u_out_ram (
        .clk, .wr_en(out_wr_en), .wr_row(out_wr_row), .wr_data(out_wr_data),
        .rd_row(out_rd_row), .rd_data(out_rd_data)
    );

    mm_array_feeder u_feeder (
        .clk, .arst_n, .load_start, .mult_start, .src_base, .row_count, .engine_clear,
        .w_rd_data, .in_rd_data, .w_rd_row, .in_rd_row, .weight_shift,
        .weight_in(feed_w), .a_in(feed_a), .stream_valid, .load_done, .busy()
    );

    for (genvar i = 0; i < array_dim; i++) begin : g_edge
        assign a_bus[i][0]      = feed_a[i];
        assign w_bus[0][i]      = feed_w[i];
        // top row starts from zero
        assign p_bus[0][i]      = '0;
        assign col_sums[i]      = p_bus[array_dim][i];
    end

    for (genvar r = 0; r < array_dim; r++) begin : g_row
        for (genvar c = 0; c < array_dim; c++) begin : g_col
            mm_mac_cell u_cell (
                .clk, .arst_n,
                .weight_shift(weight_shift[r]),
                .weight_in   (w_bus[r][c]),
                .a_in        (a_bus[r][c]),
                .psum_in     (p_bus[r][c]),
                .weight_out  (w_bus[r+1][c]),
                .a_out       (a_bus[r][c+1]),
                .psum_out    (p_bus[r+1][c])
            );
        end
    end

    mm_result_drain u_drain (
        .clk, .arst_n, .stream_valid, .col_sums, .dst_base, .engine_clear,
        .out_wr_en, .out_wr_row, .out_wr_data, .mult_done
    );

endmodule

/* verification/mm_tb.sv */
// matrix multiplier testbench
`timescale 1ns/1ns

module mm_tb import mm_pkg::*; ();

    localparam int poll_limit      = 200;
    localparam int cycles_per_line = 300;

    logic                  clk;
    logic                  arst_n;
    logic [addr_width-1:0] bus_addr;
    logic                  bus_write;
    logic                  bus_read;
    logic [bus_width-1:0]  bus_wdata;
    logic [bus_width-1:0]  bus_rdata;

    // script lines without comments
    string script_q [$];
    bit    script_loaded;
    int    error_count;
    int    test_count;
    int    test_errors;

    mm_top dut0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .bus_addr (bus_addr),
        .bus_write(bus_write),
        .bus_read (bus_read),
        .bus_wdata(bus_wdata),
        .bus_rdata(bus_rdata)
    );

    // 40 ns period
    initial clk = 1'b0;
    always #20 clk = ~clk;

    // ====================
    // helpers
    // ====================
    task automatic check_value(input logic [addr_width-1:0] addr,
                               input logic [bus_width-1:0] got,
                               input logic [bus_width-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: read of address %02h gave %08h, expected %08h",
                     $time, addr, got, exp);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("error at %0t ns: %s", $time, what);
        error_count++;
        test_errors++;
    endtask

    function automatic string strip_eol(input string s);
        string t;
        t = s;
        while (t.len() > 0 && (t[t.len()-1] == 8'h0a || t[t.len()-1] == 8'h0d)) begin
            t = t.substr(0, t.len() - 2);
        end
        return t;
    endfunction

    // ====================
    // bus operations
    // ====================
    // strobe high for one cycle and sampled at the closing edge
    task automatic write_word(input logic [addr_width-1:0] addr,
                              input logic [bus_width-1:0] data);
        @(posedge clk);
        bus_addr  <= addr;
        bus_wdata <= data;
        bus_write <= 1'b1;
        @(posedge clk);
        bus_write <= 1'b0;
    endtask

    task automatic read_word(input logic [addr_width-1:0] addr,
                             output logic [bus_width-1:0] data);
        @(posedge clk);
        bus_addr <= addr;
        bus_read <= 1'b1;
        @(posedge clk);
        bus_read <= 1'b0;
        // rdata registered at that edge and taken mid-cycle
        @(negedge clk);
        data = bus_rdata;
    endtask

    task automatic poll_status(input logic [bus_width-1:0] mask);
        logic [bus_width-1:0] status;
        int                   cycles;
        bit                   seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < poll_limit) begin
            read_word('0, status);
            seen = ((status & mask) == mask);
            // each status read spans two clock cycles
            cycles += 2;
        end
        if (!seen) begin
            note_failure($sformatf("status bits %0h never set within %0d cycles",
                                   mask, poll_limit));
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // ====================
    // script
    // ====================
    task automatic load_script();
        int    fd;
        string line;
        fd = $fopen("verification/mm_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file verification/mm_input.txt");
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0) begin
                    line = strip_eol(line);
                    if (line.len() > 0 && line[0] != "#") begin
                        script_q.push_back(line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // kind letter then hex fields or a test name
    task automatic run_line(input string line);
        byte                  kind;
        string                rest;
        logic [bus_width-1:0] a;
        logic [bus_width-1:0] b;
        logic [bus_width-1:0] got;
        int                   n;
        kind = line[0];
        rest = line.substr(2, line.len() - 1);
        n    = 0;
        case (kind)
            "W": begin
                n = $sscanf(rest, "%h %h", a, b);
                if (n == 2) write_word(a[addr_width-1:0], b);
            end
            "R": begin
                n = $sscanf(rest, "%h %h", a, b);
                if (n == 2) begin
                    read_word(a[addr_width-1:0], got);
                    check_value(a[addr_width-1:0], got, b);
                end
            end
            "P": begin
                n = $sscanf(rest, "%h", a);
                if (n == 1) poll_status(a);
                n = n + 1;
            end
            "T": begin
                end_test(rest);
                n = 2;
            end
            default: n = 0;
        endcase
        if (n != 2) note_failure($sformatf("script line not understood: %s", line));
    endtask

    initial begin
        arst_n    = 1'b0;
        bus_addr  = '0;
        bus_write = 1'b0;
        bus_read  = 1'b0;
        bus_wdata = '0;
        load_script();
        script_loaded = 1'b1;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        foreach (script_q[i]) begin
            run_line(script_q[i]);
        end
        $display("%0d tests run, %0d errors", test_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // run limit scales with script length
    initial begin
        wait (script_loaded);
        repeat ((script_q.size() + 1) * cycles_per_line) @(posedge clk);
        $display("watchdog expired, the script did not finish in time");
        $display("Testbench failed");
        $finish;
    end

endmodule

/* project.f */
src/mm_pkg.sv
src/mm_row_ram.sv
src/mm_bus_regs.sv
src/mm_array_feeder.sv
src/mm_mac_cell.sv
src/mm_result_drain.sv
src/mm_top.sv
verification/mm_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the matrix multiplier testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

build_dir=build
log_file=sim.log

rm -rf "$build_dir"
verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module mm_tb -Mdir "$build_dir" -o mm_tb_sim

"./$build_dir/mm_tb_sim" | tee "$log_file"

if grep -q "Testbench failed" "$log_file"; then
    echo "simulation reported a failure, see $log_file"
    exit 1
fi

echo "simulation finished, log in $log_file"

/* verification/mm_input.txt */
# columns, hex: W addr data | R addr expected | P status mask | T test name
# addr 7:6 region: ctrl 00, input 40+row, weight 80+row, output c0+4*row+col
R 00 00000000
W 40 7F80FF01
W 00 00000003
P 2
R C0 00000000
R C2 00000000
T reset_state
W 80 00000001
W 81 00000100
W 82 00010000
W 83 01000000
W 00 00000001
P 1
W 41 FE05FD02
W 42 10203040
W 00 00002003
P 2
R 00 00000002
R C2 FFFFFF80
R C7 FFFFFFFE
R CB 00000010
T identity_weights
W 80 0300FF02
W 81 FE0104FD
W 82 00FB0101
W 83 FF02FE00
W 00 00000001
P 1
W 43 05FE03F9
W 00 00000333
P 2
R CC FFFFFFE7
R CD 00000007
R CE 00000017
R CF FFFFFFE0
T signed_products
W 84 020100FF
W 00 00000011
P 1
W 00 00000533
P 2
R D4 00000013
R D7 0000001A
R CC FFFFFFE7
T offset_bases
W 00 0000000F
R 00 00000000
W 00 00000633
W 00 00000003
P 2
R D8 00000013
R DB 0000001A
R C2 FFFFFF80
T reset_and_busy
